// File: sim.f
rtl/dwc_pkg.sv
rtl/dwc_addr_if.sv
rtl/dwc_req_slice.sv
rtl/dwc_addr_split.sv
rtl/dwc_wdata_split.sv
rtl/dwc_b_merge.sv
rtl/dwc_r_merge.sv
rtl/dwc_downsizer.sv
tests/tb_downsizer.sv

// File: tests/tb_downsizer.sv
// Fixed-seed run against an in-order narrow subordinate model; stops at the first error.
`timescale 1ns/1ps

module tb_downsizer;

  localparam int unsigned SEED    = 32'hd643_3717;
  localparam int unsigned N_DIR   = 3;
  localparam int unsigned N_WR    = N_DIR + 24;
  localparam int unsigned N_RD    = 24;
  localparam int unsigned TIMEOUT = 200;

  logic clk_i, arst_n_i;
  logic s_aw_valid_i, s_aw_ready_o, s_w_valid_i, s_w_ready_o, s_b_valid_o, s_b_ready_i;
  logic s_ar_valid_i, s_ar_ready_o, s_r_valid_o, s_r_ready_i;
  logic [dwc_pkg::ADDR_W-1:0] s_aw_addr_i, s_ar_addr_i, m_aw_addr_o, m_ar_addr_o;
  logic [2:0] s_aw_prot_i, s_ar_prot_i, m_aw_prot_o, m_ar_prot_o;
  logic [dwc_pkg::WIDE_DATA_W-1:0] s_w_data_i, s_r_data_o;
  logic [dwc_pkg::WIDE_STRB_W-1:0] s_w_strb_i;
  logic [1:0] s_b_resp_o, s_r_resp_o, m_b_resp_i, m_r_resp_i;
  logic m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_ready_i, m_b_valid_i, m_b_ready_o;
  logic m_ar_valid_o, m_ar_ready_i, m_r_valid_i, m_r_ready_o;
  logic [dwc_pkg::NARROW_DATA_W-1:0] m_w_data_o, m_r_data_i;
  logic [dwc_pkg::NARROW_STRB_W-1:0] m_w_strb_o;

  // Wide transactions in issue order. Narrow beat n belongs to wide transaction n/2.
  logic [15:0] wr_addr [N_WR];
  logic [63:0] wr_data [N_WR];
  logic [7:0]  wr_strb [N_WR];
  logic [2:0]  wr_prot [N_WR];
  logic [15:0] rd_addr [N_RD];
  logic [2:0]  rd_prot [N_RD];
  // Responses the subordinate model has put on the narrow bus.
  logic [1:0]  b_log [2*N_WR];
  logic [31:0] r_data_log [2*N_RD];
  logic [1:0]  r_resp_log [2*N_RD];
  // Handshake counters, updated by the comparing process at the falling edge.
  int unsigned n_aw = 0, n_w = 0, n_ar = 0, n_b_acc = 0, n_r_acc = 0, n_sb = 0, n_sr = 0;
  int unsigned n_b_sent = 0, n_r_sent = 0;
  int unsigned seed_ret, wait_cycles;
  logic [51:0] exp_w;
  logic [65:0] exp_r;

  dwc_downsizer dut0 (.*);

  always #2 clk_i = ~clk_i;

  // Expected narrow beat k as {address, data lane, strobe lane}.
  function automatic logic [51:0] expand_write(input logic [15:0] addr, input logic [63:0] data,
                                               input logic [7:0] strb, input int unsigned k);
    logic [15:0] narrow_addr;
    narrow_addr = (addr & ~16'h0007) | 16'(k << 2);
    return {narrow_addr, data[k*32 +: 32], strb[k*4 +: 4]};
  endfunction

  // Expected wide read beat as {response, data}, lane 0 in the low half.
  function automatic logic [65:0] join_read(input logic [31:0] d0, input logic [31:0] d1,
                                            input logic [1:0] r0, input logic [1:0] r1);
    return {r0 | r1, d1, d0};
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic report_failure(input string what);
    $display("%0t %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  // No channel may start a transfer while the design is held in reset or idle.
  task automatic check_idle();
    assert (!m_aw_valid_o) else report_mismatch("m_aw_valid", 0, m_aw_valid_o);
    assert (!m_w_valid_o) else report_mismatch("m_w_valid", 0, m_w_valid_o);
    assert (!m_ar_valid_o) else report_mismatch("m_ar_valid", 0, m_ar_valid_o);
    assert (!s_b_valid_o) else report_mismatch("s_b_valid", 0, s_b_valid_o);
    assert (!s_r_valid_o) else report_mismatch("s_r_valid", 0, s_r_valid_o);
  endtask

  // AW and W of one wide write are offered together and may complete in different cycles.
  task automatic drive_writes();
    int unsigned cycles;
    logic aw_done, w_done;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < N_WR; i++) begin
      repeat ($urandom % 3) begin
        @(posedge clk_i);
        #1;
      end
      {s_aw_valid_i, s_aw_addr_i, s_aw_prot_i} = {1'b1, wr_addr[i], wr_prot[i]};
      {s_w_valid_i, s_w_data_i, s_w_strb_i} = {1'b1, wr_data[i], wr_strb[i]};
      aw_done = 1'b0;
      w_done = 1'b0;
      cycles = 0;
      while (!(aw_done && w_done)) begin
        @(negedge clk_i);
        aw_done = aw_done | (s_aw_valid_i & s_aw_ready_o);
        w_done = w_done | (s_w_valid_i & s_w_ready_o);
        @(posedge clk_i);
        #1;
        if (aw_done) s_aw_valid_i = 1'b0;
        if (w_done) s_w_valid_i = 1'b0;
        cycles++;
        assert (cycles < TIMEOUT) else report_failure("Wide AW or W handshake never completed.");
      end
    end
  endtask

  task automatic drive_reads();
    int unsigned cycles;
    logic done;
    @(posedge clk_i);
    #1;
    for (int i = 0; i < N_RD; i++) begin
      repeat ($urandom % 3) begin
        @(posedge clk_i);
        #1;
      end
      {s_ar_valid_i, s_ar_addr_i, s_ar_prot_i} = {1'b1, rd_addr[i], rd_prot[i]};
      done = 1'b0;
      cycles = 0;
      while (!done) begin
        @(negedge clk_i);
        done = s_ar_valid_i & s_ar_ready_o;
        @(posedge clk_i);
        #1;
        if (done) s_ar_valid_i = 1'b0;
        cycles++;
        assert (cycles < TIMEOUT) else report_failure("Wide AR handshake never completed.");
      end
    end
  endtask

  // Random ready gaps on the narrow request channels and on the wide response channels.
  always begin
    @(posedge clk_i);
    #1;
    m_aw_ready_i = ($urandom % 4) != 0;
    m_w_ready_i  = ($urandom % 4) != 0;
    m_ar_ready_i = ($urandom % 4) != 0;
    s_b_ready_i  = ($urandom % 3) != 0;
    s_r_ready_i  = ($urandom % 3) != 0;
  end

  // A narrow B may only follow both its AW and its W beat; it is held until accepted.
  always begin
    @(posedge clk_i);
    #1;
    if (n_b_sent == n_b_acc) begin
      m_b_valid_i = 1'b0;
      if ((n_b_sent < n_aw) && (n_b_sent < n_w) && (($urandom % 3) != 0)) begin
        m_b_resp_i = 2'($urandom);
        b_log[n_b_sent] = m_b_resp_i;
        n_b_sent++;
        m_b_valid_i = 1'b1;
      end
    end
  end

  // Narrow R beats come back in AR order with random data and response.
  always begin
    @(posedge clk_i);
    #1;
    if (n_r_sent == n_r_acc) begin
      m_r_valid_i = 1'b0;
      if ((n_r_sent < n_ar) && (($urandom % 3) != 0)) begin
        m_r_data_i = $urandom;
        m_r_resp_i = 2'($urandom);
        r_data_log[n_r_sent] = m_r_data_i;
        r_resp_log[n_r_sent] = m_r_resp_i;
        n_r_sent++;
        m_r_valid_i = 1'b1;
      end
    end
  end

  // Compares every handshake seen at the falling edge, where all signals have settled.
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        assert (n_aw < 2*N_WR) else report_failure("Narrow AW beat beyond the issued writes.");
        exp_w = expand_write(wr_addr[n_aw/2], wr_data[n_aw/2], wr_strb[n_aw/2], n_aw % 2);
        assert (m_aw_addr_o == exp_w[51:36])
          else report_mismatch("m_aw_addr", exp_w[51:36], m_aw_addr_o);
        assert (m_aw_prot_o == wr_prot[n_aw/2])
          else report_mismatch("m_aw_prot", wr_prot[n_aw/2], m_aw_prot_o);
        n_aw++;
      end
      if (m_w_valid_o && m_w_ready_i) begin
        assert (n_w < 2*N_WR) else report_failure("Narrow W beat beyond the issued writes.");
        exp_w = expand_write(wr_addr[n_w/2], wr_data[n_w/2], wr_strb[n_w/2], n_w % 2);
        assert (m_w_data_o == exp_w[35:4])
          else report_mismatch("m_w_data", exp_w[35:4], m_w_data_o);
        assert (m_w_strb_o == exp_w[3:0])
          else report_mismatch("m_w_strb", exp_w[3:0], m_w_strb_o);
        n_w++;
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        assert (n_ar < 2*N_RD) else report_failure("Narrow AR beat beyond the issued reads.");
        exp_w = expand_write(rd_addr[n_ar/2], '0, '0, n_ar % 2);
        assert (m_ar_addr_o == exp_w[51:36])
          else report_mismatch("m_ar_addr", exp_w[51:36], m_ar_addr_o);
        assert (m_ar_prot_o == rd_prot[n_ar/2])
          else report_mismatch("m_ar_prot", rd_prot[n_ar/2], m_ar_prot_o);
        n_ar++;
      end
      // A wide response must coincide with the second narrow response of its pair.
      if (s_b_valid_o && s_b_ready_i) begin
        assert (n_sb < N_WR) else report_failure("Wide B response without an issued write.");
        assert (n_b_acc == 2*n_sb + 1)
          else report_mismatch("narrow B count", 2*n_sb + 1, n_b_acc);
        assert (s_b_resp_o == (b_log[2*n_sb] | b_log[2*n_sb+1]))
          else report_mismatch("s_b_resp", b_log[2*n_sb] | b_log[2*n_sb+1], s_b_resp_o);
        n_sb++;
      end
      if (m_b_valid_i && m_b_ready_o) n_b_acc++;
      if (s_r_valid_o && s_r_ready_i) begin
        assert (n_sr < N_RD) else report_failure("Wide R beat without an issued read.");
        assert (n_r_acc == 2*n_sr + 1)
          else report_mismatch("narrow R count", 2*n_sr + 1, n_r_acc);
        exp_r = join_read(r_data_log[2*n_sr], r_data_log[2*n_sr+1],
                          r_resp_log[2*n_sr], r_resp_log[2*n_sr+1]);
        assert (s_r_data_o == exp_r[63:0])
          else report_mismatch("s_r_data", exp_r[63:0], s_r_data_o);
        assert (s_r_resp_o == exp_r[65:64])
          else report_mismatch("s_r_resp", exp_r[65:64], s_r_resp_o);
        n_sr++;
      end
      if (m_r_valid_i && m_r_ready_o) n_r_acc++;
    end
  end

  initial begin
    seed_ret = $urandom(SEED);
    {clk_i, arst_n_i, s_aw_valid_i, s_w_valid_i, s_ar_valid_i, s_b_ready_i, s_r_ready_i} = '0;
    {s_aw_addr_i, s_aw_prot_i, s_ar_addr_i, s_ar_prot_i, s_w_data_i, s_w_strb_i} = '0;
    {m_aw_ready_i, m_w_ready_i, m_ar_ready_i, m_b_valid_i, m_r_valid_i} = '0;
    {m_b_resp_i, m_r_resp_i, m_r_data_i} = '0;
    // Directed writes: an unaligned address with upper-lane strobes, a full word, a lane-1 address.
    {wr_addr[0], wr_data[0]} = {16'h0005, 64'h0123_4567_89ab_cdef};
    {wr_strb[0], wr_prot[0]} = {8'he0, 3'd2};
    {wr_addr[1], wr_data[1]} = {16'h0010, 64'hdead_beef_cafe_f00d};
    {wr_strb[1], wr_prot[1]} = {8'hff, 3'd0};
    {wr_addr[2], wr_data[2]} = {16'h00fc, 64'h1111_2222_3333_4444};
    {wr_strb[2], wr_prot[2]} = {8'h0f, 3'd5};
    for (int i = N_DIR; i < N_WR; i++) begin
      wr_addr[i] = 16'($urandom);
      wr_data[i] = {$urandom, $urandom};
      wr_strb[i] = 8'($urandom);
      wr_prot[i] = 3'($urandom);
    end
    for (int i = 0; i < N_RD; i++) begin
      rd_addr[i] = 16'($urandom);
      rd_prot[i] = 3'($urandom);
    end
    repeat (16) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_idle();
    end
    fork
      drive_writes();
      drive_reads();
    join
    wait_cycles = 0;
    while ((n_sb < N_WR) || (n_sr < N_RD)) begin
      @(posedge clk_i);
      wait_cycles++;
      assert (wait_cycles < 20*TIMEOUT) else report_failure("Wide responses stopped arriving.");
    end
    // Idle cycles to catch any surplus beat after the last response.
    repeat (20) @(posedge clk_i);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: rtl/dwc_downsizer.sv
// AXI4-Lite 64-to-32 bit downsizer; narrow responses must come back in request order.
`timescale 1ns/1ps

module dwc_downsizer (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  // Wide side, facing the manager.
  input  logic                              s_aw_valid_i,
  output logic                              s_aw_ready_o,
  input  logic [dwc_pkg::ADDR_W-1:0]        s_aw_addr_i,
  input  logic [2:0]                        s_aw_prot_i,
  input  logic                              s_w_valid_i,
  output logic                              s_w_ready_o,
  input  logic [dwc_pkg::WIDE_DATA_W-1:0]   s_w_data_i,
  input  logic [dwc_pkg::WIDE_STRB_W-1:0]   s_w_strb_i,
  output logic                              s_b_valid_o,
  input  logic                              s_b_ready_i,
  output logic [1:0]                        s_b_resp_o,
  input  logic                              s_ar_valid_i,
  output logic                              s_ar_ready_o,
  input  logic [dwc_pkg::ADDR_W-1:0]        s_ar_addr_i,
  input  logic [2:0]                        s_ar_prot_i,
  output logic                              s_r_valid_o,
  input  logic                              s_r_ready_i,
  output logic [dwc_pkg::WIDE_DATA_W-1:0]   s_r_data_o,
  output logic [1:0]                        s_r_resp_o,
  // Narrow side, facing the subordinate.
  output logic                              m_aw_valid_o,
  input  logic                              m_aw_ready_i,
  output logic [dwc_pkg::ADDR_W-1:0]        m_aw_addr_o,
  output logic [2:0]                        m_aw_prot_o,
  output logic                              m_w_valid_o,
  input  logic                              m_w_ready_i,
  output logic [dwc_pkg::NARROW_DATA_W-1:0] m_w_data_o,
  output logic [dwc_pkg::NARROW_STRB_W-1:0] m_w_strb_o,
  input  logic                              m_b_valid_i,
  output logic                              m_b_ready_o,
  input  logic [1:0]                        m_b_resp_i,
  output logic                              m_ar_valid_o,
  input  logic                              m_ar_ready_i,
  output logic [dwc_pkg::ADDR_W-1:0]        m_ar_addr_o,
  output logic [2:0]                        m_ar_prot_o,
  input  logic                              m_r_valid_i,
  output logic                              m_r_ready_o,
  input  logic [dwc_pkg::NARROW_DATA_W-1:0] m_r_data_i,
  input  logic [1:0]                        m_r_resp_i
);

  // Links between each address slice and its splitter.
  dwc_addr_if aw_chan ();
  dwc_addr_if ar_chan ();

  // Input side. Each address channel enters through its own spill register.
  dwc_req_slice u_aw_slice (
    .clk_i, .arst_n_i, .valid_i(s_aw_valid_i), .ready_o(s_aw_ready_o),
    .addr_i(s_aw_addr_i), .prot_i(s_aw_prot_i), .chan(aw_chan)
  );
  dwc_req_slice u_ar_slice (
    .clk_i, .arst_n_i, .valid_i(s_ar_valid_i), .ready_o(s_ar_ready_o),
    .addr_i(s_ar_addr_i), .prot_i(s_ar_prot_i), .chan(ar_chan)
  );

  // Processing part. Addresses and write data are cut into narrow beats.
  dwc_addr_split u_aw_split (
    .clk_i, .arst_n_i, .chan(aw_chan), .valid_o(m_aw_valid_o),
    .ready_i(m_aw_ready_i), .addr_o(m_aw_addr_o), .prot_o(m_aw_prot_o)
  );
  dwc_addr_split u_ar_split (
    .clk_i, .arst_n_i, .chan(ar_chan), .valid_o(m_ar_valid_o),
    .ready_i(m_ar_ready_i), .addr_o(m_ar_addr_o), .prot_o(m_ar_prot_o)
  );
  dwc_wdata_split u_w_split (
    .clk_i, .arst_n_i, .s_valid_i(s_w_valid_i), .s_ready_o(s_w_ready_o),
    .s_data_i(s_w_data_i), .s_strb_i(s_w_strb_i), .m_valid_o(m_w_valid_o),
    .m_ready_i(m_w_ready_i), .m_data_o(m_w_data_o), .m_strb_o(m_w_strb_o)
  );

  // Output side. Narrow responses are merged back into wide ones.
  dwc_b_merge u_b_merge (
    .clk_i, .arst_n_i, .m_valid_i(m_b_valid_i), .m_ready_o(m_b_ready_o),
    .m_resp_i(m_b_resp_i), .s_valid_o(s_b_valid_o), .s_ready_i(s_b_ready_i),
    .s_resp_o(s_b_resp_o)
  );
  dwc_r_merge u_r_merge (
    .clk_i, .arst_n_i, .m_valid_i(m_r_valid_i), .m_ready_o(m_r_ready_o),
    .m_data_i(m_r_data_i), .m_resp_i(m_r_resp_i), .s_valid_o(s_r_valid_o),
    .s_ready_i(s_r_ready_i), .s_data_o(s_r_data_o), .s_resp_o(s_r_resp_o)
  );

endmodule

// File: rtl/dwc_r_merge.sv
// Joins DOWNSIZE narrow R beats into one wide beat; the last lane is fed through unregistered.
`timescale 1ns/1ps

module dwc_r_merge (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              m_valid_i,
  output logic                              m_ready_o,
  input  logic [dwc_pkg::NARROW_DATA_W-1:0] m_data_i,
  input  dwc_pkg::resp_t                    m_resp_i,
  output logic                              s_valid_o,
  input  logic                              s_ready_i,
  output dwc_pkg::wide_word_u               s_data_o,
  output dwc_pkg::resp_t                    s_resp_o
);

  // Lane of the next expected narrow beat.
  dwc_pkg::lane_t lane_q;
  // Data of the lanes below the last one.
  logic [dwc_pkg::DOWNSIZE-2:0][dwc_pkg::NARROW_DATA_W-1:0] data_q;
  // Worst response of the beats collected so far.
  dwc_pkg::resp_t resp_q;
  logic           last_lane;
  logic           beat_done;

  assign last_lane = (lane_q == dwc_pkg::lane_t'(dwc_pkg::DOWNSIZE - 1));
  assign beat_done = m_valid_i & m_ready_o;

  // Same handshake scheme as the B merger.
  assign m_ready_o = last_lane ? s_ready_i : 1'b1;
  assign s_valid_o = last_lane & m_valid_i;
  assign s_resp_o  = resp_q | m_resp_i;

  // Fill the wide word lane by lane. The top lane comes from the narrow port.
  always_comb begin
    for (int unsigned i = 0; i < dwc_pkg::DOWNSIZE - 1; i++) begin
      s_data_o.lane[i] = data_q[i];
    end
    s_data_o.lane[dwc_pkg::DOWNSIZE-1] = m_data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_q <= '0;
      resp_q <= dwc_pkg::RESP_OKAY;
    end else if (beat_done) begin
      lane_q <= dwc_pkg::lane_t'(lane_q + 1'b1);
      if (last_lane) begin
        resp_q <= dwc_pkg::RESP_OKAY;
      end else begin
        resp_q <= resp_q | m_resp_i;
      end
    end
  end

  // Capture the lanes below the last one as they arrive.
  always_ff @(posedge clk_i) begin
    if (beat_done && !last_lane) begin
      data_q[lane_q] <= m_data_i;
    end
  end

  // Stable only if the narrow subordinate also holds its last beat.
  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (s_valid_o && !s_ready_i) |=> $stable(s_data_o))
    else $error("Wide R data changed before it was accepted.");

endmodule

// File: rtl/dwc_b_merge.sv
// Merges DOWNSIZE narrow B responses into one; relies on the narrow subordinate answering in order.
`timescale 1ns/1ps

module dwc_b_merge (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           m_valid_i,
  output logic           m_ready_o,
  input  dwc_pkg::resp_t m_resp_i,
  output logic           s_valid_o,
  input  logic           s_ready_i,
  output dwc_pkg::resp_t s_resp_o
);

  // Lane of the next expected narrow response.
  dwc_pkg::lane_t lane_q;
  // Worst response seen so far for the current wide write.
  dwc_pkg::resp_t resp_q;
  logic           last_lane;
  logic           beat_done;

  assign last_lane = (lane_q == dwc_pkg::lane_t'(dwc_pkg::DOWNSIZE - 1));
  assign beat_done = m_valid_i & m_ready_o;

  // Earlier responses are absorbed at once.
  // The last one waits for the wide side, so back-pressure passes through.
  assign m_ready_o = last_lane ? s_ready_i : 1'b1;
  assign s_valid_o = last_lane & m_valid_i;
  assign s_resp_o  = resp_q | m_resp_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_q <= '0;
      resp_q <= dwc_pkg::RESP_OKAY;
    end else if (beat_done) begin
      lane_q <= dwc_pkg::lane_t'(lane_q + 1'b1);
      // Start clean for the next wide write once the merged response is handed over.
      if (last_lane) begin
        resp_q <= dwc_pkg::RESP_OKAY;
      end else begin
        resp_q <= resp_q | m_resp_i;
      end
    end
  end

endmodule

// File: rtl/dwc_wdata_split.sv
// Splits each wide W beat into DOWNSIZE narrow beats in lane order, lane 0 first.
`timescale 1ns/1ps

module dwc_wdata_split (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              s_valid_i,
  output logic                              s_ready_o,
  input  dwc_pkg::wide_word_u               s_data_i,
  input  dwc_pkg::wide_strb_u               s_strb_i,
  output logic                              m_valid_o,
  input  logic                              m_ready_i,
  output logic [dwc_pkg::NARROW_DATA_W-1:0] m_data_o,
  output logic [dwc_pkg::NARROW_STRB_W-1:0] m_strb_o
);

  // Head and tail of the W spill register.
  logic                head_valid_q;
  dwc_pkg::wide_word_u head_data_q;
  dwc_pkg::wide_strb_u head_strb_q;
  logic                tail_valid_q;
  dwc_pkg::wide_word_u tail_data_q;
  dwc_pkg::wide_strb_u tail_strb_q;
  // Lane of the next narrow beat.
  dwc_pkg::lane_t      lane_q;
  logic                last_lane;
  logic                beat_done;
  logic                push;
  logic                pop;

  assign s_ready_o = ~tail_valid_q;
  assign push      = s_valid_i & s_ready_o;

  assign last_lane = (lane_q == dwc_pkg::lane_t'(dwc_pkg::DOWNSIZE - 1));
  assign beat_done = m_valid_o & m_ready_i;
  // The wide beat leaves the register after its last lane is accepted.
  assign pop       = beat_done & last_lane;

  // Both unions are read as lanes, so the counter selects data and strobe alike.
  assign m_valid_o = head_valid_q;
  assign m_data_o  = head_data_q.lane[lane_q];
  assign m_strb_o  = head_strb_q.lane[lane_q];

  // Control state of the spill register and the lane counter.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_valid_q <= 1'b0;
      tail_valid_q <= 1'b0;
      lane_q       <= '0;
    end else begin
      if (beat_done) begin
        lane_q <= dwc_pkg::lane_t'(lane_q + 1'b1);
      end
      if (push && !pop) begin
        if (head_valid_q) begin
          tail_valid_q <= 1'b1;
        end else begin
          head_valid_q <= 1'b1;
        end
      end else if (pop && !push) begin
        if (tail_valid_q) begin
          tail_valid_q <= 1'b0;
        end else begin
          head_valid_q <= 1'b0;
        end
      end
    end
  end

  // Payload moves, following the same rules as the address slices.
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (tail_valid_q) begin
        head_data_q <= tail_data_q;
        head_strb_q <= tail_strb_q;
      end else if (push) begin
        head_data_q <= s_data_i;
        head_strb_q <= s_strb_i;
      end
    end else if (push) begin
      if (head_valid_q) begin
        tail_data_q <= s_data_i;
        tail_strb_q <= s_strb_i;
      end else begin
        head_data_q <= s_data_i;
        head_strb_q <= s_strb_i;
      end
    end
  end

  // A stalled narrow beat must keep its strobes until it is taken.
  a_strb_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (m_valid_o && !m_ready_i) |=> $stable(m_strb_o))
    else $error("Narrow W strobe changed under back-pressure.");

endmodule

// File: rtl/dwc_addr_split.sv
// Issues DOWNSIZE narrow-aligned addresses per wide request; the low address bits are discarded.
`timescale 1ns/1ps

module dwc_addr_split (
  input  logic           clk_i,
  input  logic           arst_n_i,
  dwc_addr_if.split_mp   chan,
  output logic           valid_o,
  input  logic           ready_i,
  output dwc_pkg::addr_t addr_o,
  output dwc_pkg::prot_t prot_o
);

  // Lane of the next narrow beat to issue.
  dwc_pkg::lane_t lane_q;
  logic           last_lane;
  logic           beat_done;

  assign last_lane = (lane_q == dwc_pkg::lane_t'(dwc_pkg::DOWNSIZE - 1));
  assign beat_done = valid_o & ready_i;

  // Every narrow beat of the wide request is presented straight from the slice head.
  assign valid_o = chan.valid;
  assign prot_o  = chan.prot;

  // The slice entry is released only with the handshake of the last beat.
  assign chan.ready = ready_i & last_lane;

  // Replace the lane bits by the counter and clear the byte offset.
  always_comb begin
    addr_o = chan.addr;
    addr_o[dwc_pkg::LANE_OFFSET +: dwc_pkg::LANE_W] = lane_q;
    addr_o[dwc_pkg::LANE_OFFSET-1:0] = '0;
  end

  // The counter wraps back to lane 0 after the last beat.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lane_q <= '0;
    end else if (beat_done) begin
      lane_q <= dwc_pkg::lane_t'(lane_q + 1'b1);
    end
  end

  // Holds only if the slice keeps its head stable and the counter waits for the handshake.
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_o && !ready_i) |=> $stable(addr_o))
    else $error("Narrow address changed before it was accepted.");

endmodule

// File: rtl/dwc_req_slice.sv
// Two-entry spill register for AW or AR; ready depends only on its own fill, never on the output.
`timescale 1ns/1ps

module dwc_req_slice (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           valid_i,
  output logic           ready_o,
  input  dwc_pkg::addr_t addr_i,
  input  dwc_pkg::prot_t prot_i,
  dwc_addr_if.slice_mp   chan
);

  // The head entry is the one presented downstream.
  logic           head_valid_q;
  dwc_pkg::addr_t head_addr_q;
  dwc_pkg::prot_t head_prot_q;
  // The tail entry only fills while the head is stalled.
  logic           tail_valid_q;
  dwc_pkg::addr_t tail_addr_q;
  dwc_pkg::prot_t tail_prot_q;
  logic           push;
  logic           pop;
  logic [1:0]     fill;

  // There is room while the tail is free.
  assign ready_o = ~tail_valid_q;
  assign push    = valid_i & ready_o;
  assign pop     = head_valid_q & chan.ready;
  assign fill    = {1'b0, head_valid_q} + {1'b0, tail_valid_q};

  // The output is registered, so a new request shows up one cycle after acceptance.
  assign chan.valid = head_valid_q;
  assign chan.addr  = head_addr_q;
  assign chan.prot  = head_prot_q;

  // Occupancy tracking. The tail is only valid when the head is valid too.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_valid_q <= 1'b0;
      tail_valid_q <= 1'b0;
    end else if (push && !pop) begin
      if (head_valid_q) begin
        tail_valid_q <= 1'b1;
      end else begin
        head_valid_q <= 1'b1;
      end
    end else if (pop && !push) begin
      if (tail_valid_q) begin
        tail_valid_q <= 1'b0;
      end else begin
        head_valid_q <= 1'b0;
      end
    end
  end

  // Payload moves. A push with a pop always finds the tail empty.
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (tail_valid_q) begin
        head_addr_q <= tail_addr_q;
        head_prot_q <= tail_prot_q;
      end else if (push) begin
        head_addr_q <= addr_i;
        head_prot_q <= prot_i;
      end
    end else if (push) begin
      if (head_valid_q) begin
        tail_addr_q <= addr_i;
        tail_prot_q <= prot_i;
      end else begin
        head_addr_q <= addr_i;
        head_prot_q <= prot_i;
      end
    end
  end

  // An accepted request that is not released at the same time must raise the fill by one.
  a_no_loss: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (push && !pop) |=> (fill == $past(fill) + 2'd1))
    else $error("Request slice dropped an accepted entry.");

endmodule

// File: rtl/dwc_addr_if.sv
// Address channel from a request slice to its splitter; ready is pulsed only on the last lane.
`timescale 1ns/1ps

interface dwc_addr_if;

  // The slice presents its oldest entry on these lines.
  logic           valid;
  dwc_pkg::addr_t addr;
  dwc_pkg::prot_t prot;
  // The splitter releases the entry once every lane has been issued.
  logic           ready;

  // Request slice side.
  modport slice_mp (
    output valid,
    output addr,
    output prot,
    input  ready
  );

  // Address splitter side.
  modport split_mp (
    input  valid,
    input  addr,
    input  prot,
    output ready
  );

endinterface

// File: rtl/dwc_pkg.sv
// Widths are fixed here for a 64-bit to 32-bit downsizer; other ratios need new lane types.
package dwc_pkg;

  // Address width on both sides of the converter.
  localparam int unsigned ADDR_W        = 16;
  // The wide side carries twice the data of the narrow side.
  localparam int unsigned WIDE_DATA_W   = 64;
  localparam int unsigned NARROW_DATA_W = 32;
  // One strobe bit per byte.
  localparam int unsigned WIDE_STRB_W   = WIDE_DATA_W / 8;
  localparam int unsigned NARROW_STRB_W = NARROW_DATA_W / 8;
  // Number of narrow beats that make up one wide beat.
  localparam int unsigned DOWNSIZE      = WIDE_DATA_W / NARROW_DATA_W;
  // The lane index selects one narrow beat inside a wide beat.
  localparam int unsigned LANE_W        = 1;
  // Address bits below this offset address bytes within one narrow word.
  localparam int unsigned LANE_OFFSET   = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [2:0]        prot_t;
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [1:0]        resp_t;

  // OKAY is all zeros, so OR-ing responses keeps the worst one.
  localparam resp_t RESP_OKAY = 2'b00;

  // A wide data word, seen either flat or as narrow lanes.
  // Lane 0 holds the lowest bits, which matches the lowest narrow address.
  typedef union packed {
    logic [WIDE_DATA_W-1:0]                   flat;
    logic [DOWNSIZE-1:0][NARROW_DATA_W-1:0]   lane;
  } wide_word_u;

  // The matching strobe word, seen flat or as per-lane strobes.
  typedef union packed {
    logic [WIDE_STRB_W-1:0]                   flat;
    logic [DOWNSIZE-1:0][NARROW_STRB_W-1:0]   lane;
  } wide_strb_u;

endpackage
